// File: filelist.f
+incdir+src
src/bus_types_pkg.sv
src/scenario_pkg.sv
src/master_cmd_if.sv
src/scenario_controller.sv
src/bus_master.sv
src/bus_interconnect.sv
src/wb_mem_slave.sv
src/bus_top.sv
sim/tb_clock_gen.sv
sim/bus_assertions.sv
sim/bus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the bus testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module bus_tb \
    -f filelist.f -o bus_tb_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/bus_tb_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "result: FAIL"; exit 1; }
grep -q "Simulation PASSED" sim.log && { echo "result: PASS"; exit 0; }
echo "result: FAIL, no pass message in sim.log"
exit 1

// File: sim/bus_tb.sv
`timescale 1ns/1ns

module bus_tb;
    import bus_types_pkg::*;
    import scenario_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int N_DIRECTED   = 40;
    localparam int N_RANDOM     = 200;
    localparam int DONE_LIMIT   = 40;
    localparam int WATCHDOG_NS  = ((N_DIRECTED + N_RANDOM) * 40 + RESET_CYCLES) * CLK_PERIOD;

    // a predicted field is compared only when its chk bit is set
    typedef struct packed {
        logic      chk_err1;
        logic      err1;
        logic      chk_rd1;
        bus_data_t rd1;
        logic      chk_err2;
        logic      err2;
        logic      chk_rd2;
        bus_data_t rd2;
    } expect_t;

    logic      clk;
    logic      rst_n;
    logic      start;
    scenario_t scenario;
    bus_addr_t m1_addr;
    bus_addr_t m2_addr;
    bus_data_t m1_wdata;
    bus_data_t m2_wdata;
    logic      busy;
    logic      done;
    bus_data_t m1_rdata;
    bus_data_t m2_rdata;
    logic      m1_err;
    logic      m2_err;

    bus_data_t model_mem [3][256];
    expect_t   exp_q [$];
    int        checks;
    int        value_errors;
    int        other_errors;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock_gen_i (
        .clk(clk), .rst_n(rst_n)
    );

    bus_top bus_top_i (
        .clk(clk), .rst_n(rst_n), .start(start), .scenario(scenario),
        .m1_addr(m1_addr), .m1_wdata(m1_wdata), .m2_addr(m2_addr), .m2_wdata(m2_wdata),
        .busy(busy), .done(done),
        .m1_rdata(m1_rdata), .m1_err(m1_err), .m2_rdata(m2_rdata), .m2_err(m2_err)
    );

    task automatic check(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // unmapped slave gives err and leaves the model alone
    function automatic void model_access(input logic we, input bus_addr_t a, input bus_data_t d,
                                         output bus_data_t rd, output logic err);
        slave_sel_t  s;
        mem_offset_t o;
        s   = a[13:12];
        o   = a[7:0];
        rd  = '0;
        err = (s == 2'd3);
        if (!err) begin
            rd = model_mem[s][o];
            if (we)
                model_mem[s][o] = d;
        end
    endfunction

    function automatic expect_t expect_scenario(input scenario_t sc,
                                                input bus_addr_t a1, input bus_data_t d1,
                                                input bus_addr_t a2, input bus_data_t d2);
        expect_t   e;
        logic      go1, we1, go2, we2;
        bus_data_t rd;
        logic      err;
        e = '0;
        case (sc)
            sc_m1_write:    {go1, we1, go2, we2} = 4'b1100;
            sc_m1_read:     {go1, we1, go2, we2} = 4'b1000;
            sc_m2_write:    {go1, we1, go2, we2} = 4'b0011;
            sc_m2_read:     {go1, we1, go2, we2} = 4'b0010;
            sc_both_write:  {go1, we1, go2, we2} = 4'b1111;
            sc_both_read:   {go1, we1, go2, we2} = 4'b1010;
            sc_m1w_m2r:     {go1, we1, go2, we2} = 4'b1110;
            sc_m1r_m2w:     {go1, we1, go2, we2} = 4'b1011;
            sc_split_write: {go1, we1, go2, we2} = 4'b1111;
            default:        {go1, we1, go2, we2} = 4'b0000;
        endcase
        // master 1 always wins the bus first
        if (go1) begin
            model_access(we1, a1, d1, rd, err);
            {e.chk_err1, e.err1, e.chk_rd1, e.rd1} = {1'b1, err, !we1 && !err, rd};
        end
        if (go2) begin
            model_access(we2, a2, d2, rd, err);
            {e.chk_err2, e.err2, e.chk_rd2, e.rd2} = {1'b1, err, !we2 && !err, rd};
        end
        return e;
    endfunction

    function automatic bus_addr_t rand_addr();
        return {2'($urandom_range(3, 0)), 4'($urandom), 8'($urandom_range(15, 0))};
    endfunction

    // poke raises a second start while the first scenario is still busy
    task automatic run_scenario(input scenario_t sc, input bus_addr_t a1, input bus_data_t d1,
                                input bus_addr_t a2, input bus_data_t d2, input bit poke);
        int cycles;
        cycles = 0;
        @(posedge clk);
        start    <= 1'b1;
        scenario <= sc;
        m1_addr  <= a1;
        m1_wdata <= d1;
        m2_addr  <= a2;
        m2_wdata <= d2;
        exp_q.push_back(expect_scenario(sc, a1, d1, a2, d2));
        do begin
            @(posedge clk);
            start <= poke && (cycles == 2);
            if (poke && cycles == 2) begin
                m1_wdata <= ~d1;
                m2_wdata <= ~d2;
            end
            @(negedge clk);
            cycles++;
            check("busy", 8'(busy), 8'(!done));
        end while (!done && cycles < DONE_LIMIT);
        if (!done) begin
            $display("scenario %0d gave no done within %0d cycles", sc, DONE_LIMIT);
            other_errors++;
            exp_q.delete();
        end
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            check("busy while idle", 8'(busy), 8'h00);
            check("done while idle", 8'(done), 8'h00);
        end
    endtask

    task automatic start_invalid(input logic [3:0] num);
        @(posedge clk);
        start    <= 1'b1;
        scenario <= scenario_t'(num);
        m1_wdata <= 8'hee;
        @(posedge clk);
        start <= 1'b0;
        expect_quiet(20);
    endtask

    // compare on each done pulse
    always @(negedge clk) begin
        expect_t e;
        if (rst_n && done) begin
            if (exp_q.size() == 0) begin
                $display("done pulsed at %0t ns with no scenario started", $time);
                other_errors++;
            end else begin
                e = exp_q.pop_front();
                if (e.chk_err1)
                    check("m1_err", 8'(m1_err), 8'(e.err1));
                if (e.chk_rd1)
                    check("m1_rdata", m1_rdata, e.rd1);
                if (e.chk_err2)
                    check("m2_err", 8'(m2_err), 8'(e.err2));
                if (e.chk_rd2)
                    check("m2_rdata", m2_rdata, e.rd2);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        start        = 1'b0;
        scenario     = sc_m1_write;
        m1_addr      = '0;
        m2_addr      = '0;
        m1_wdata     = '0;
        m2_wdata     = '0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        void'($urandom(32'he920));
        foreach (model_mem[s, o])
            model_mem[s][o] = '0;
        @(posedge rst_n);

        // memories come out of reset cleared
        run_scenario(sc_m1_read, 14'h0010, 8'h00, 14'h0000, 8'h00, 1'b0);
        run_scenario(sc_m2_read, 14'h0000, 8'h00, 14'h1010, 8'h00, 1'b0);
        run_scenario(sc_both_read, 14'h20ff, 8'h00, 14'h0001, 8'h00, 1'b0);
        for (int s = 0; s < 3; s++) begin
            run_scenario(sc_m1_write, {2'(s), 12'h021}, 8'(8'ha0 + s), 14'h0000, 8'h00, 1'b0);
            run_scenario(sc_m1_read, {2'(s), 12'h021}, 8'h00, 14'h0000, 8'h00, 1'b0);
            run_scenario(sc_m2_write, 14'h0000, 8'h00, {2'(s), 12'h042}, 8'(8'hb0 + s), 1'b0);
            run_scenario(sc_m2_read, 14'h0000, 8'h00, {2'(s), 12'h042}, 8'h00, 1'b0);
        end
        // master 1 goes first when both masters hit one address
        run_scenario(sc_both_write, 14'h1080, 8'h11, 14'h1080, 8'h22, 1'b0);
        run_scenario(sc_m1_read, 14'h1080, 8'h00, 14'h0000, 8'h00, 1'b0);
        run_scenario(sc_both_read, 14'h1080, 8'h00, 14'h1080, 8'h00, 1'b0);
        run_scenario(sc_m1w_m2r, 14'h2090, 8'h33, 14'h2090, 8'h00, 1'b0);
        run_scenario(sc_m1r_m2w, 14'h2090, 8'h00, 14'h2090, 8'h44, 1'b0);
        run_scenario(sc_m1_read, 14'h2090, 8'h00, 14'h0000, 8'h00, 1'b0);
        // slave 3 is unmapped and bits 11:8 alias
        run_scenario(sc_m1_write, 14'h3005, 8'h55, 14'h0000, 8'h00, 1'b0);
        run_scenario(sc_m2_read, 14'h0000, 8'h00, 14'h3005, 8'h00, 1'b0);
        run_scenario(sc_m1_read, 14'h0005, 8'h00, 14'h0000, 8'h00, 1'b0);
        run_scenario(sc_m1_write, 14'h0a40, 8'h66, 14'h0000, 8'h00, 1'b0);
        run_scenario(sc_m2_read, 14'h0000, 8'h00, 14'h0340, 8'h00, 1'b0);
        run_scenario(sc_split_write, 14'h10c0, 8'h77, 14'h00c1, 8'h88, 1'b0);
        run_scenario(sc_both_read, 14'h10c0, 8'h00, 14'h00c1, 8'h00, 1'b0);
        // starts that must be ignored
        run_scenario(sc_m1_write, 14'h10d0, 8'h99, 14'h0000, 8'h00, 1'b1);
        expect_quiet(10);
        start_invalid(4'd0);
        start_invalid(4'd12);
        run_scenario(sc_m1_read, 14'h10d0, 8'h00, 14'h0000, 8'h00, 1'b0);

        for (int n = 0; n < N_RANDOM; n++) begin
            run_scenario(scenario_t'(4'($urandom_range(9, 1))), rand_addr(), 8'($urandom),
                         rand_addr(), 8'($urandom), 1'b0);
        end

        repeat (2) @(posedge clk);
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end
endmodule

// File: sim/bus_assertions.sv
`timescale 1ns/1ns
`include "bus_settings.svh"

module bus_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   m1_cyc,
    input logic                   m1_ack,
    input logic                   m1_err,
    input logic                   m2_cyc,
    input logic                   m2_ack,
    input logic                   m2_err,
    input logic [`NUM_SLAVES-1:0] s_stb,
    input logic [`NUM_SLAVES-1:0] s_ack
);
    a_m1_ack_err: assert property (@(posedge clk) disable iff (!rst_n) !(m1_ack && m1_err))
        else $error("master 1 sees ack and err in the same cycle");
    a_m2_ack_err: assert property (@(posedge clk) disable iff (!rst_n) !(m2_ack && m2_err))
        else $error("master 2 sees ack and err in the same cycle");

    // at most one slave strobed
    a_stb_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(s_stb))
        else $error("more than one slave strobe active");
    a_ack_in_stb: assert property (@(posedge clk) disable iff (!rst_n) (s_ack & ~s_stb) == '0)
        else $error("slave ack without its strobe");

    // a classic cycle stays open until it is terminated
    a_m1_cyc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m1_cyc && !m1_ack && !m1_err |=> m1_cyc)
        else $error("master 1 dropped cyc before ack or err");
    a_m2_cyc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m2_cyc && !m2_ack && !m2_err |=> m2_cyc)
        else $error("master 2 dropped cyc before ack or err");
endmodule

bind bus_interconnect bus_assertions bus_assertions_i (
    .clk(clk), .rst_n(rst_n),
    .m1_cyc(m1_cyc), .m1_ack(m1_ack), .m1_err(m1_err),
    .m2_cyc(m2_cyc), .m2_ack(m2_ack), .m2_err(m2_err),
    .s_stb(s_stb), .s_ack(s_ack)
);

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset leaves on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end
endmodule

// File: src/bus_top.sv
`timescale 1ns/1ns
`include "bus_settings.svh"

module bus_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  scenario_pkg::scenario_t  scenario,
    input  bus_types_pkg::bus_addr_t m1_addr,
    input  bus_types_pkg::bus_data_t m1_wdata,
    input  bus_types_pkg::bus_addr_t m2_addr,
    input  bus_types_pkg::bus_data_t m2_wdata,
    output logic                     busy,
    output logic                     done,
    output bus_types_pkg::bus_data_t m1_rdata,
    output logic                     m1_err,
    output bus_types_pkg::bus_data_t m2_rdata,
    output logic                     m2_err
);
    import bus_types_pkg::*;

    master_cmd_if m1_cmd_if ();
    master_cmd_if m2_cmd_if ();

    // master side links
    logic        m1_cyc, m1_stb, m1_we, m1_ack, m1_berr;
    logic        m2_cyc, m2_stb, m2_we, m2_ack, m2_berr;
    bus_addr_t   m1_adr, m2_adr;
    bus_data_t   m1_dat_w, m1_dat_r, m2_dat_w, m2_dat_r;

    // slave side links
    logic [`NUM_SLAVES-1:0] s_cyc, s_stb, s_we, s_ack;
    mem_offset_t            s_adr [`NUM_SLAVES];
    bus_data_t              s_dat_w [`NUM_SLAVES];
    bus_data_t              s_dat_r [`NUM_SLAVES];

    scenario_controller ctrl_i (
        .clk, .rst_n, .start, .scenario,
        .m1_addr, .m2_addr, .m1_wdata, .m2_wdata,
        .m1_cmd(m1_cmd_if.ctrl), .m2_cmd(m2_cmd_if.ctrl),
        .busy, .done
    );

    bus_master master1_i (
        .clk, .rst_n, .cmd(m1_cmd_if.master),
        .cyc(m1_cyc), .stb(m1_stb), .we(m1_we), .adr(m1_adr), .dat_w(m1_dat_w),
        .dat_r(m1_dat_r), .ack(m1_ack), .err(m1_berr)
    );

    bus_master master2_i (
        .clk, .rst_n, .cmd(m2_cmd_if.master),
        .cyc(m2_cyc), .stb(m2_stb), .we(m2_we), .adr(m2_adr), .dat_w(m2_dat_w),
        .dat_r(m2_dat_r), .ack(m2_ack), .err(m2_berr)
    );

    bus_interconnect icon_i (
        .clk, .rst_n,
        .m1_cyc, .m1_stb, .m1_we, .m1_adr, .m1_dat_w, .m1_dat_r, .m1_ack, .m1_err(m1_berr),
        .m2_cyc, .m2_stb, .m2_we, .m2_adr, .m2_dat_w, .m2_dat_r, .m2_ack, .m2_err(m2_berr),
        .s_cyc, .s_stb, .s_we, .s_adr, .s_dat_w, .s_dat_r, .s_ack
    );

    // slave 1 carries the extra wait states
    for (genvar i = 0; i < `NUM_SLAVES; i++) begin : g_slave
        wb_mem_slave #(.WAIT_STATES(i == 1 ? `SLOW_WAIT : 0)) slave_i (
            .clk, .rst_n,
            .cyc(s_cyc[i]), .stb(s_stb[i]), .we(s_we[i]), .adr(s_adr[i]),
            .dat_w(s_dat_w[i]), .dat_r(s_dat_r[i]), .ack(s_ack[i])
        );
    end

    assign m1_rdata = m1_cmd_if.rdata;
    assign m1_err   = m1_cmd_if.err;
    assign m2_rdata = m2_cmd_if.rdata;
    assign m2_err   = m2_cmd_if.err;

endmodule

// File: src/wb_mem_slave.sv
`timescale 1ns/1ns
`include "bus_settings.svh"

module wb_mem_slave #(
    parameter int WAIT_STATES = 0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  bus_types_pkg::mem_offset_t adr,
    input  bus_types_pkg::bus_data_t   dat_w,
    output bus_types_pkg::bus_data_t   dat_r,
    output logic                       ack
);
    import bus_types_pkg::*;

    localparam int DEPTH = 1 << `SLAVE_AW;
    localparam int CW    = $clog2(WAIT_STATES + 2);

    bus_data_t       mem [DEPTH];
    logic [CW-1:0]   wait_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack      <= 1'b0;
            wait_cnt <= '0;
            dat_r    <= '0;
            for (int i = 0; i < DEPTH; i++)
                mem[i] <= '0;
        end else if (cyc && stb && !ack) begin
            if (wait_cnt == CW'(WAIT_STATES)) begin
                // ack rises WAIT_STATES + 1 cycles after stb
                ack      <= 1'b1;
                wait_cnt <= '0;
                dat_r    <= mem[adr];
                if (we)
                    mem[adr] <= dat_w;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end else begin
            ack      <= 1'b0;
            wait_cnt <= '0;
        end
    end

endmodule

// File: src/bus_interconnect.sv
`timescale 1ns/1ns
`include "bus_settings.svh"

module bus_interconnect (
    input  logic                        clk,
    input  logic                        rst_n,
    // master 1 link
    input  logic                        m1_cyc,
    input  logic                        m1_stb,
    input  logic                        m1_we,
    input  bus_types_pkg::bus_addr_t    m1_adr,
    input  bus_types_pkg::bus_data_t    m1_dat_w,
    output bus_types_pkg::bus_data_t    m1_dat_r,
    output logic                        m1_ack,
    output logic                        m1_err,
    // master 2 link
    input  logic                        m2_cyc,
    input  logic                        m2_stb,
    input  logic                        m2_we,
    input  bus_types_pkg::bus_addr_t    m2_adr,
    input  bus_types_pkg::bus_data_t    m2_dat_w,
    output bus_types_pkg::bus_data_t    m2_dat_r,
    output logic                        m2_ack,
    output logic                        m2_err,
    // slave links
    output logic [`NUM_SLAVES-1:0]      s_cyc,
    output logic [`NUM_SLAVES-1:0]      s_stb,
    output logic [`NUM_SLAVES-1:0]      s_we,
    output bus_types_pkg::mem_offset_t  s_adr [`NUM_SLAVES],
    output bus_types_pkg::bus_data_t    s_dat_w [`NUM_SLAVES],
    input  bus_types_pkg::bus_data_t    s_dat_r [`NUM_SLAVES],
    input  logic [`NUM_SLAVES-1:0]      s_ack
);
    import bus_types_pkg::*;

    logic       gnt_valid;
    logic       gnt_m2;
    logic       err_q;
    logic       sel_cyc;
    logic       sel_stb;
    logic       sel_we;
    bus_addr_t  sel_adr;
    bus_data_t  sel_dat_w;
    slave_sel_t sel;
    logic       hit;
    logic       slv_ack;
    bus_data_t  slv_dat;

    // granted master onto the shared path
    assign sel_cyc   = gnt_valid && (gnt_m2 ? m2_cyc : m1_cyc);
    assign sel_stb   = gnt_valid && (gnt_m2 ? m2_stb : m1_stb);
    assign sel_we    = gnt_m2 ? m2_we : m1_we;
    assign sel_adr   = gnt_m2 ? m2_adr : m1_adr;
    assign sel_dat_w = gnt_m2 ? m2_dat_w : m1_dat_w;
    assign sel       = slave_sel_t'(sel_adr[`BUS_AW-1 -: 2]);

    always_comb begin
        hit     = 1'b0;
        slv_ack = 1'b0;
        slv_dat = '0;
        for (int i = 0; i < `NUM_SLAVES; i++) begin
            s_cyc[i]   = sel_cyc && (sel == slave_sel_t'(i));
            s_stb[i]   = sel_stb && (sel == slave_sel_t'(i));
            s_we[i]    = sel_we;
            s_adr[i]   = mem_offset_t'(sel_adr[`SLAVE_AW-1:0]);
            s_dat_w[i] = sel_dat_w;
            if (sel == slave_sel_t'(i)) begin
                hit     = 1'b1;
                slv_ack = s_ack[i];
                slv_dat = s_dat_r[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_valid <= 1'b0;
            gnt_m2    <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            // master 1 has priority when the grant is free
            if (!gnt_valid) begin
                if (m1_cyc) begin
                    gnt_valid <= 1'b1;
                    gnt_m2    <= 1'b0;
                end else if (m2_cyc) begin
                    gnt_valid <= 1'b1;
                    gnt_m2    <= 1'b1;
                end
            end else if (!sel_cyc) begin
                gnt_valid <= 1'b0;
            end
            // unmapped access, err one cycle after stb
            err_q <= sel_cyc && sel_stb && !hit && !err_q;
        end
    end

    assign m1_ack   = gnt_valid && !gnt_m2 && slv_ack;
    assign m1_err   = gnt_valid && !gnt_m2 && err_q;
    assign m2_ack   = gnt_valid && gnt_m2 && slv_ack;
    assign m2_err   = gnt_valid && gnt_m2 && err_q;
    assign m1_dat_r = slv_dat;
    assign m2_dat_r = slv_dat;

endmodule

// File: src/bus_master.sv
`timescale 1ns/1ns

module bus_master (
    input  logic                     clk,
    input  logic                     rst_n,
    master_cmd_if.master             cmd,
    output logic                     cyc,
    output logic                     stb,
    output logic                     we,
    output bus_types_pkg::bus_addr_t adr,
    output bus_types_pkg::bus_data_t dat_w,
    input  bus_types_pkg::bus_data_t dat_r,
    input  logic                     ack,
    input  logic                     err
);
    import bus_types_pkg::*;

    logic active;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            cmd.err <= 1'b0;
        end else if (!active) begin
            if (cmd.cmd_valid) begin
                active  <= 1'b1;
                cmd.err <= 1'b0;
            end
        end else if (ack || err) begin
            // cycle ends, cyc and stb drop on the next edge
            active  <= 1'b0;
            cmd.err <= err;
        end
    end

    // outputs stay frozen while the cycle is open
    always_ff @(posedge clk) begin
        if (!active && cmd.cmd_valid) begin
            we    <= cmd.cmd_we;
            adr   <= cmd.cmd_addr;
            dat_w <= cmd.cmd_wdata;
        end
        if (active && (ack || err) && !we)
            cmd.rdata <= dat_r;
    end

    assign cyc      = active;
    assign stb      = active;
    assign cmd.busy = active;

endmodule

// File: src/scenario_controller.sv
`timescale 1ns/1ns
`include "bus_settings.svh"

module scenario_controller (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  scenario_pkg::scenario_t scenario,
    input  bus_types_pkg::bus_addr_t m1_addr,
    input  bus_types_pkg::bus_addr_t m2_addr,
    input  bus_types_pkg::bus_data_t m1_wdata,
    input  bus_types_pkg::bus_data_t m2_wdata,
    master_cmd_if.ctrl              m1_cmd,
    master_cmd_if.ctrl              m2_cmd,
    output logic                    busy,
    output logic                    done
);
    import bus_types_pkg::*;
    import scenario_pkg::*;

    localparam int DLY_W = $clog2(`SPLIT_DELAY);

    ctrl_state_t      state;
    ctrl_state_t      state_nx;
    logic [DLY_W-1:0] dly_cnt;
    logic             accept;

    // decoded view of the incoming scenario number
    logic dec_valid;
    logic dec_m1_go;
    logic dec_m1_we;
    logic dec_m2_go;
    logic dec_m2_we;
    logic dec_split;

    // captured at accept
    logic      m1_go;
    logic      m1_we;
    logic      m2_go;
    logic      m2_we;
    logic      split;
    bus_addr_t m1_addr_q;
    bus_addr_t m2_addr_q;
    bus_data_t m1_wdata_q;
    bus_data_t m2_wdata_q;

    always_comb begin
        {dec_valid, dec_m1_go, dec_m1_we, dec_m2_go, dec_m2_we, dec_split} = '0;
        case (scenario)
            sc_m1_write:    {dec_valid, dec_m1_go, dec_m1_we} = 3'b111;
            sc_m1_read:     {dec_valid, dec_m1_go} = 2'b11;
            sc_m2_write:    {dec_valid, dec_m2_go, dec_m2_we} = 3'b111;
            sc_m2_read:     {dec_valid, dec_m2_go} = 2'b11;
            sc_both_write:  {dec_valid, dec_m1_go, dec_m1_we, dec_m2_go, dec_m2_we} = 5'b11111;
            sc_both_read:   {dec_valid, dec_m1_go, dec_m2_go} = 3'b111;
            sc_m1w_m2r:     {dec_valid, dec_m1_go, dec_m1_we, dec_m2_go} = 4'b1111;
            sc_m1r_m2w:     {dec_valid, dec_m1_go, dec_m2_go, dec_m2_we} = 4'b1111;
            sc_split_write: begin
                {dec_valid, dec_m1_go, dec_m1_we, dec_m2_go, dec_m2_we} = 5'b11111;
                dec_split = 1'b1;
            end
            default: dec_valid = 1'b0;
        endcase
    end

    // done shares the cycle with busy low, so a new start is taken there too
    assign accept = start && dec_valid && (state == st_idle || state == st_done);

    always_comb begin
        state_nx = state;
        case (state)
            st_idle, st_done: state_nx = accept ? st_issue : st_idle;
            st_issue:         state_nx = split ? st_delay : st_wait;
            st_delay: begin
                if (dly_cnt == DLY_W'(`SPLIT_DELAY - 2))
                    state_nx = st_issue2;
            end
            st_issue2:        state_nx = st_wait;
            st_wait: begin
                if (!m1_cmd.busy && !m2_cmd.busy)
                    state_nx = st_done;
            end
            default:          state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            dly_cnt <= '0;
            {m1_go, m1_we, m2_go, m2_we, split} <= '0;
        end else begin
            state <= state_nx;
            if (state == st_delay)
                dly_cnt <= dly_cnt + 1'b1;
            else
                dly_cnt <= '0;
            if (accept)
                {m1_go, m1_we, m2_go, m2_we, split} <=
                    {dec_m1_go, dec_m1_we, dec_m2_go, dec_m2_we, dec_split};
        end
    end

    // operands from the top-level ports
    always_ff @(posedge clk) begin
        if (accept) begin
            m1_addr_q  <= m1_addr;
            m2_addr_q  <= m2_addr;
            m1_wdata_q <= m1_wdata;
            m2_wdata_q <= m2_wdata;
        end
    end

    assign m1_cmd.cmd_valid = (state == st_issue) && m1_go;
    assign m1_cmd.cmd_we    = m1_we;
    assign m1_cmd.cmd_addr  = m1_addr_q;
    assign m1_cmd.cmd_wdata = m1_wdata_q;

    // in the split case master 2 goes out from st_issue2 instead
    assign m2_cmd.cmd_valid = m2_go && ((state == st_issue && !split) || state == st_issue2);
    assign m2_cmd.cmd_we    = m2_we;
    assign m2_cmd.cmd_addr  = m2_addr_q;
    assign m2_cmd.cmd_wdata = m2_wdata_q;

    assign busy = (state != st_idle) && (state != st_done);
    assign done = (state == st_done);

endmodule

// File: src/master_cmd_if.sv
`timescale 1ns/1ns

interface master_cmd_if;
    import bus_types_pkg::*;

    // command, one-cycle pulse on cmd_valid
    logic      cmd_valid;
    logic      cmd_we;
    bus_addr_t cmd_addr;
    bus_data_t cmd_wdata;

    // result, valid once busy has fallen
    logic      busy;
    bus_data_t rdata;
    logic      err;

    modport ctrl (
        output cmd_valid, cmd_we, cmd_addr, cmd_wdata,
        input  busy, rdata, err
    );

    modport master (
        input  cmd_valid, cmd_we, cmd_addr, cmd_wdata,
        output busy, rdata, err
    );

endinterface

// File: src/scenario_pkg.sv
package scenario_pkg;

    // scenario numbers as seen on the start interface
    typedef enum logic [3:0] {
        sc_m1_write    = 4'd1,
        sc_m1_read     = 4'd2,
        sc_m2_write    = 4'd3,
        sc_m2_read     = 4'd4,
        sc_both_write  = 4'd5,
        sc_both_read   = 4'd6,
        sc_m1w_m2r     = 4'd7,
        sc_m1r_m2w     = 4'd8,
        sc_split_write = 4'd9
    } scenario_t;

    // controller FSM
    typedef enum logic [2:0] {
        st_idle,
        st_issue,
        st_delay,
        st_issue2,
        st_wait,
        st_done
    } ctrl_state_t;

endpackage

// File: src/bus_types_pkg.sv
`include "bus_settings.svh"

package bus_types_pkg;

    // full bus address, bits 13:12 pick the slave
    typedef logic [`BUS_AW-1:0] bus_addr_t;

    // one data byte
    typedef logic [`BUS_DW-1:0] bus_data_t;

    // slave index, value 3 is unmapped
    typedef logic [1:0] slave_sel_t;

    // offset inside one slave memory, bits 11:8 of the address alias
    typedef logic [`SLAVE_AW-1:0] mem_offset_t;

endpackage

// File: src/bus_settings.svh
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// bus geometry
`define BUS_AW 14
`define BUS_DW 8
`define SLAVE_AW 8
`define NUM_SLAVES 3

// slave 1 is the slow one
`define SLOW_WAIT 3

// cycles from master 1's command to master 2's in the split scenario
`define SPLIT_DELAY 10

`endif
